//--- source/logb_pkg.sv
package logb_pkg;

  //////////////////////////////////////////////////
  // channel table
  //////////////////////////////////////////////////

  // data-carrying channels and event-only channels
  localparam int LOGB_CHANNEL_CNT = 4;
  localparam int LOGE_CHANNEL_CNT = 2;

  // data width per logb channel, source order, index 0 in the low slot
  localparam bit [LOGB_CHANNEL_CNT-1:0][6:0] CHANNEL_WIDTHS = {7'd32, 7'd24, 7'd16, 7'd8};

  // bit offset of each source channel inside the unpacked data word
  localparam bit [LOGB_CHANNEL_CNT-1:0][6:0] LEAF_OFFSETS = {7'd48, 7'd24, 7'd8, 7'd0};

  // sum of all channel widths
  localparam int TOTAL_WIDTH = 80;

  //////////////////////////////////////////////////
  // merge plan
  //////////////////////////////////////////////////

  // source channel feeding each tree leaf: leaf0=ch2, leaf1=ch0, leaf2=ch3, leaf3=ch1
  localparam bit [LOGB_CHANNEL_CNT-1:0][1:0] SHUFFLE_PLAN = {2'd1, 2'd3, 2'd0, 2'd2};

  // leaf layer plus two merge layers, also the packer latency
  localparam int MERGE_TREE_HEIGHT = 3;

  // fixed-width vectors
  typedef logic [TOTAL_WIDTH-1:0]      logb_data_t;
  typedef logic [6:0]                  logb_len_t;
  typedef logic [LOGB_CHANNEL_CNT-1:0] logb_valid_t;
  typedef logic [LOGE_CHANNEL_CNT-1:0] loge_valid_t;
  typedef logic [11:0]                 fill_t;

  // unpacked input bus, data in source order (86 bits)
  typedef struct packed {
    logb_valid_t logb_valid;
    loge_valid_t loge_valid;
    logb_data_t  logb_data;
  } logging_in_t;

  // dense word, data only meaningful below len while any_valid (88 bits)
  typedef struct packed {
    logic       any_valid;
    logb_len_t  len;
    logb_data_t data;
  } packed_logb_t;

  // output bus, logb_valid is in shuffled leaf order
  typedef struct packed {
    logb_valid_t  logb_valid;
    loge_valid_t  loge_valid;
    packed_logb_t plogb;
  } packed_logging_t;

endpackage

//--- source/valid_delay_pipe.sv
`timescale 1ns/100ps

module valid_delay_pipe #(
  parameter int WIDTH  = 1,
  parameter int STAGES = 1
) (
  input  logic             clk,
  input  logic             rstn,
  input  logic [WIDTH-1:0] in_bus,
  output logic [WIDTH-1:0] out_bus
);

  // one register per stage, stage 0 samples the input
  logic [STAGES-1:0][WIDTH-1:0] stage_q;

  always_ff @(posedge clk) begin
    if (!rstn) begin
      // valids and flags come out of reset low
      stage_q <= '0;
    end else begin
      stage_q[0] <= in_bus;
      // shift toward the last stage
      for (int i = 1; i < STAGES; i++) begin
        stage_q[i] <= stage_q[i-1];
      end
    end
  end

  // delayed by exactly STAGES cycles
  assign out_bus = stage_q[STAGES-1];

endmodule

//--- source/logb_marshaller2.sv
`timescale 1ns/100ps

module logb_marshaller2 #(
  parameter int WIDTH_A = 8,
  parameter int WIDTH_B = 8
) (
  input  logic                                  clk,
  input  logic                                  rstn,
  input  logic                                  a_valid,
  input  logic [$clog2(WIDTH_A+1)-1:0]          a_len,
  input  logic [WIDTH_A-1:0]                    a_data,
  input  logic                                  b_valid,
  input  logic [$clog2(WIDTH_B+1)-1:0]          b_len,
  input  logic [WIDTH_B-1:0]                    b_data,
  output logic                                  out_valid,
  output logic [$clog2(WIDTH_A+WIDTH_B+1)-1:0]  out_len,
  output logic [WIDTH_A+WIDTH_B-1:0]            out_data
);

  localparam int LEN_A_W = $clog2(WIDTH_A+1);
  localparam int LEN_B_W = $clog2(WIDTH_B+1);
  localparam int LEN_O_W = $clog2(WIDTH_A+WIDTH_B+1);

  //////////////////////////////////////////////////
  // input registers
  //////////////////////////////////////////////////

  logic               a_valid_q, b_valid_q;
  logic [LEN_A_W-1:0] a_len_q;
  logic [LEN_B_W-1:0] b_len_q;
  logic [WIDTH_A-1:0] a_data_q;
  logic [WIDTH_B-1:0] b_data_q;

  // valid flags are the only control state here
  always_ff @(posedge clk) begin
    if (!rstn) begin
      a_valid_q <= 1'b0;
      b_valid_q <= 1'b0;
    end else begin
      a_valid_q <= a_valid;
      b_valid_q <= b_valid;
    end
  end

  always_ff @(posedge clk) begin
    a_len_q  <= a_len;
    b_len_q  <= b_len;
    a_data_q <= a_data;
    b_data_q <= b_data;
  end

  //////////////////////////////////////////////////
  // join by valid length
  //////////////////////////////////////////////////

  logic [LEN_A_W-1:0] a_cnt;
  logic [LEN_B_W-1:0] b_cnt;

  always_comb begin
    // an invalid side contributes no bits
    a_cnt   = a_valid_q ? a_len_q : '0;
    b_cnt   = b_valid_q ? b_len_q : '0;
    out_len = LEN_O_W'(a_cnt) + LEN_O_W'(b_cnt);
    // a sits at bit 0, b lands right after a's counted bits
    out_data = (WIDTH_A+WIDTH_B)'(a_data_q);
    out_data[a_cnt +: WIDTH_B] = b_data_q;
  end

  assign out_valid = a_valid_q | b_valid_q;

endmodule

//--- source/logging_bus_packer.sv
`timescale 1ns/100ps

module logging_bus_packer (
  input  logic                      clk,
  input  logic                      rstn,
  input  logb_pkg::logging_in_t     log_in,
  output logb_pkg::packed_logging_t log_out,
  input  logic                      almful,
  output logic                      logb_almful
);

  // leaf widths in shuffled order
  localparam int W0 = logb_pkg::CHANNEL_WIDTHS[logb_pkg::SHUFFLE_PLAN[0]];
  localparam int W1 = logb_pkg::CHANNEL_WIDTHS[logb_pkg::SHUFFLE_PLAN[1]];
  localparam int W2 = logb_pkg::CHANNEL_WIDTHS[logb_pkg::SHUFFLE_PLAN[2]];
  localparam int W3 = logb_pkg::CHANNEL_WIDTHS[logb_pkg::SHUFFLE_PLAN[3]];
  // layer 1 node widths
  localparam int L1A_W = W0 + W1;
  localparam int L1B_W = W2 + W3;

  //////////////////////////////////////////////////
  // leaf extraction
  //////////////////////////////////////////////////

  logb_pkg::logb_valid_t shuf_valid;

  for (genvar i = 0; i < logb_pkg::LOGB_CHANNEL_CNT; i++) begin : leaf
    localparam int SRC    = logb_pkg::SHUFFLE_PLAN[i];
    localparam int WIDTH  = logb_pkg::CHANNEL_WIDTHS[SRC];
    localparam int OFFSET = logb_pkg::LEAF_OFFSETS[SRC];
    localparam int LEN_W  = $clog2(WIDTH+1);

    logic             valid;
    logic [LEN_W-1:0] len;
    logic [WIDTH-1:0] data;

    assign valid = log_in.logb_valid[SRC];
    // full channel width when valid, nothing otherwise
    assign len   = valid ? LEN_W'(WIDTH) : '0;
    assign data  = log_in.logb_data[OFFSET +: WIDTH];
    // valid bits follow the same shuffle as the data
    assign shuf_valid[i] = valid;
  end

  //////////////////////////////////////////////////
  // merge tree
  //////////////////////////////////////////////////

  // layer 1 outputs
  logic                         l1a_valid, l1b_valid;
  logic [$clog2(L1A_W+1)-1:0]   l1a_len;
  logic [$clog2(L1B_W+1)-1:0]   l1b_len;
  logic [L1A_W-1:0]             l1a_data;
  logic [L1B_W-1:0]             l1b_data;
  // layer 2 output, full width
  logic                         l2_valid;
  logb_pkg::logb_len_t          l2_len;
  logb_pkg::logb_data_t         l2_data;

  // leaves 0 and 1
  logb_marshaller2 #(.WIDTH_A(W0), .WIDTH_B(W1)) u_merge_l1a (
    .clk       (clk),
    .rstn      (rstn),
    .a_valid   (leaf[0].valid),
    .a_len     (leaf[0].len),
    .a_data    (leaf[0].data),
    .b_valid   (leaf[1].valid),
    .b_len     (leaf[1].len),
    .b_data    (leaf[1].data),
    .out_valid (l1a_valid),
    .out_len   (l1a_len),
    .out_data  (l1a_data)
  );

  // leaves 2 and 3
  logb_marshaller2 #(.WIDTH_A(W2), .WIDTH_B(W3)) u_merge_l1b (
    .clk       (clk),
    .rstn      (rstn),
    .a_valid   (leaf[2].valid),
    .a_len     (leaf[2].len),
    .a_data    (leaf[2].data),
    .b_valid   (leaf[3].valid),
    .b_len     (leaf[3].len),
    .b_data    (leaf[3].data),
    .out_valid (l1b_valid),
    .out_len   (l1b_len),
    .out_data  (l1b_data)
  );

  // root node
  logb_marshaller2 #(.WIDTH_A(L1A_W), .WIDTH_B(L1B_W)) u_merge_l2 (
    .clk       (clk),
    .rstn      (rstn),
    .a_valid   (l1a_valid),
    .a_len     (l1a_len),
    .a_data    (l1a_data),
    .b_valid   (l1b_valid),
    .b_len     (l1b_len),
    .b_data    (l1b_data),
    .out_valid (l2_valid),
    .out_len   (l2_len),
    .out_data  (l2_data)
  );

  // output register, third cycle of latency
  logb_pkg::packed_logb_t plogb_q;

  always_ff @(posedge clk) begin
    if (!rstn) begin
      plogb_q.any_valid <= 1'b0;
    end else begin
      plogb_q.any_valid <= l2_valid;
    end
  end

  always_ff @(posedge clk) begin
    plogb_q.len  <= l2_len;
    plogb_q.data <= l2_data;
  end

  //////////////////////////////////////////////////
  // side-band delays
  //////////////////////////////////////////////////

  logb_pkg::logb_valid_t logb_valid_d;
  logb_pkg::loge_valid_t loge_valid_d;

  valid_delay_pipe #(
    .WIDTH  (logb_pkg::LOGB_CHANNEL_CNT),
    .STAGES (logb_pkg::MERGE_TREE_HEIGHT)
  ) u_logb_valid_pipe (
    .clk     (clk),
    .rstn    (rstn),
    .in_bus  (shuf_valid),
    .out_bus (logb_valid_d)
  );

  // event channels keep source order
  valid_delay_pipe #(
    .WIDTH  (logb_pkg::LOGE_CHANNEL_CNT),
    .STAGES (logb_pkg::MERGE_TREE_HEIGHT)
  ) u_loge_valid_pipe (
    .clk     (clk),
    .rstn    (rstn),
    .in_bus  (log_in.loge_valid),
    .out_bus (loge_valid_d)
  );

  // almful heads back toward the producers, advisory only
  valid_delay_pipe #(
    .WIDTH  (1),
    .STAGES (logb_pkg::MERGE_TREE_HEIGHT)
  ) u_almful_pipe (
    .clk     (clk),
    .rstn    (rstn),
    .in_bus  (almful),
    .out_bus (logb_almful)
  );

  assign log_out.logb_valid = logb_valid_d;
  assign log_out.loge_valid = loge_valid_d;
  assign log_out.plogb      = plogb_q;

endmodule

//--- source/trace_fill_monitor.sv
`timescale 1ns/100ps

module trace_fill_monitor #(
  parameter int ALMFUL_THRESHOLD = 256
) (
  input  logic                   clk,
  input  logic                   rstn,
  input  logb_pkg::packed_logb_t plogb,
  input  logb_pkg::fill_t        drain_bits,
  output logic                   almful
);

  // saturation ceiling of the fill counter
  localparam int FILL_MAX = 2**$bits(logb_pkg::fill_t) - 1;

  //////////////////////////////////////////////////
  // fill level
  //////////////////////////////////////////////////

  logb_pkg::fill_t    fill_q;
  logic signed [13:0] fill_sum;
  logic               almful_q;

  // two guard bits cover overflow and underflow
  always_comb begin
    fill_sum = 14'(fill_q);
    if (plogb.any_valid) begin
      fill_sum = fill_sum + 14'(plogb.len);
    end
    fill_sum = fill_sum - 14'(drain_bits);
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      fill_q <= '0;
    end else if (fill_sum < 0) begin
      // drained more than was held
      fill_q <= '0;
    end else if (fill_sum > FILL_MAX) begin
      fill_q <= '1;
    end else begin
      fill_q <= logb_pkg::fill_t'(fill_sum);
    end
  end

  // one cycle behind the fill update
  always_ff @(posedge clk) begin
    if (!rstn) begin
      almful_q <= 1'b0;
    end else begin
      almful_q <= (fill_q >= logb_pkg::fill_t'(ALMFUL_THRESHOLD));
    end
  end

  assign almful = almful_q;

endmodule

//--- source/trace_logger_top.sv
`timescale 1ns/100ps

module trace_logger_top #(
  parameter int ALMFUL_THRESHOLD = 256
) (
  input  logic                      clk,
  input  logic                      rstn,
  input  logb_pkg::logging_in_t     log_in,
  input  logb_pkg::fill_t           drain_bits,
  output logb_pkg::packed_logging_t log_out,
  output logic                      logb_almful
);

  //////////////////////////////////////////////////
  // internal wiring
  //////////////////////////////////////////////////

  // raw almost-full from the monitor, before the return delay
  logic almful;

  //////////////////////////////////////////////////
  // packing stage
  //////////////////////////////////////////////////

  // log_in at cycle t shows on log_out at t+3
  logging_bus_packer u_packer (
    .clk         (clk),
    .rstn        (rstn),
    .log_in      (log_in),
    .log_out     (log_out),
    .almful      (almful),
    .logb_almful (logb_almful)
  );

  //////////////////////////////////////////////////
  // trace buffer fill tracking
  //////////////////////////////////////////////////

  // counts the packed word as it leaves the top level
  // drain_bits stands in for the buffer consumer
  trace_fill_monitor #(
    .ALMFUL_THRESHOLD (ALMFUL_THRESHOLD)
  ) u_fill_monitor (
    .clk        (clk),
    .rstn       (rstn),
    .plogb      (log_out.plogb),
    .drain_bits (drain_bits),
    .almful     (almful)
  );

  // almful reaches the producers five cycles after the
  // monitor sees the crossing word, never stalling the tree

endmodule

//--- verif/trace_logger_tb_table.svh
`ifndef TRACE_LOGGER_TB_TABLE_SVH
`define TRACE_LOGGER_TB_TABLE_SVH

localparam int ROW_CNT = 38;

// test names up to 16 characters
typedef logic [8*16-1:0] name_t;

// one row per cycle: stimulus, then the outputs expected three cycles later
typedef struct packed {
  name_t                 name;
  logb_pkg::logb_valid_t logb_mask;
  logb_pkg::loge_valid_t loge_mask;
  logb_pkg::fill_t       drain;
  logb_pkg::logb_valid_t exp_logb_valid;
  logb_pkg::loge_valid_t exp_loge_valid;
  logb_pkg::logb_len_t   exp_len;
  logic                  exp_almful;
} row_t;

row_t rows [ROW_CNT];

function automatic row_t table_row(
  input name_t name, input logb_pkg::logb_valid_t logb_mask,
  input logb_pkg::loge_valid_t loge_mask, input logb_pkg::fill_t drain,
  input logb_pkg::logb_valid_t exp_logb_valid, input logb_pkg::loge_valid_t exp_loge_valid,
  input logb_pkg::logb_len_t exp_len, input logic exp_almful
);
  row_t row;
  row.name           = name;
  row.logb_mask      = logb_mask;
  row.loge_mask      = loge_mask;
  row.drain          = drain;
  row.exp_logb_valid = exp_logb_valid;
  row.exp_loge_valid = exp_loge_valid;
  row.exp_len        = exp_len;
  row.exp_almful     = exp_almful;
  return row;
endfunction

task automatic load_table();
  // a drain of 80 keeps up with any single word, fill stays at 0
  rows[0]  = table_row("single_ch0", 4'b0001, 2'b00, 12'd80, 4'b0010, 2'b00, 7'd8, 1'b0);
  rows[1]  = table_row("single_ch1", 4'b0010, 2'b00, 12'd80, 4'b1000, 2'b00, 7'd16, 1'b0);
  rows[2]  = table_row("single_ch2", 4'b0100, 2'b00, 12'd80, 4'b0001, 2'b00, 7'd24, 1'b0);
  rows[3]  = table_row("single_ch3", 4'b1000, 2'b00, 12'd80, 4'b0100, 2'b00, 7'd32, 1'b0);
  // every mask back to back, shuffled valid is {m1, m3, m0, m2}
  rows[4]  = table_row("mask_0000", 4'b0000, 2'b00, 12'd80, 4'b0000, 2'b00, 7'd0, 1'b0);
  rows[5]  = table_row("mask_0001", 4'b0001, 2'b00, 12'd80, 4'b0010, 2'b00, 7'd8, 1'b0);
  rows[6]  = table_row("mask_0010", 4'b0010, 2'b00, 12'd80, 4'b1000, 2'b00, 7'd16, 1'b0);
  rows[7]  = table_row("mask_0011", 4'b0011, 2'b00, 12'd80, 4'b1010, 2'b00, 7'd24, 1'b0);
  rows[8]  = table_row("mask_0100", 4'b0100, 2'b00, 12'd80, 4'b0001, 2'b00, 7'd24, 1'b0);
  rows[9]  = table_row("mask_0101", 4'b0101, 2'b00, 12'd80, 4'b0011, 2'b00, 7'd32, 1'b0);
  rows[10] = table_row("mask_0110", 4'b0110, 2'b00, 12'd80, 4'b1001, 2'b00, 7'd40, 1'b0);
  rows[11] = table_row("mask_0111", 4'b0111, 2'b00, 12'd80, 4'b1011, 2'b00, 7'd48, 1'b0);
  rows[12] = table_row("mask_1000", 4'b1000, 2'b00, 12'd80, 4'b0100, 2'b00, 7'd32, 1'b0);
  rows[13] = table_row("mask_1001", 4'b1001, 2'b00, 12'd80, 4'b0110, 2'b00, 7'd40, 1'b0);
  rows[14] = table_row("mask_1010", 4'b1010, 2'b00, 12'd80, 4'b1100, 2'b00, 7'd48, 1'b0);
  rows[15] = table_row("mask_1011", 4'b1011, 2'b00, 12'd80, 4'b1110, 2'b00, 7'd56, 1'b0);
  rows[16] = table_row("mask_1100", 4'b1100, 2'b00, 12'd80, 4'b0101, 2'b00, 7'd56, 1'b0);
  rows[17] = table_row("mask_1101", 4'b1101, 2'b00, 12'd80, 4'b0111, 2'b00, 7'd64, 1'b0);
  rows[18] = table_row("mask_1110", 4'b1110, 2'b00, 12'd80, 4'b1101, 2'b00, 7'd72, 1'b0);
  rows[19] = table_row("mask_1111", 4'b1111, 2'b00, 12'd80, 4'b1111, 2'b00, 7'd80, 1'b0);
  // event channels, the last three carry no logb data
  rows[20] = table_row("event_0", 4'b0110, 2'b01, 12'd80, 4'b1001, 2'b01, 7'd40, 1'b0);
  rows[21] = table_row("event_1", 4'b1001, 2'b10, 12'd80, 4'b0110, 2'b10, 7'd40, 1'b0);
  rows[22] = table_row("event_2", 4'b0000, 2'b11, 12'd80, 4'b0000, 2'b11, 7'd0, 1'b0);
  rows[23] = table_row("event_3", 4'b0000, 2'b10, 12'd80, 4'b0000, 2'b10, 7'd0, 1'b0);
  rows[24] = table_row("event_4", 4'b0000, 2'b01, 12'd80, 4'b0000, 2'b01, 7'd0, 1'b0);
  // fill 80, 160, 240, 320 after almful_03, almful seen five rows later
  rows[25] = table_row("almful_00", 4'b1111, 2'b00, 12'd0, 4'b1111, 2'b00, 7'd80, 1'b0);
  rows[26] = table_row("almful_01", 4'b1111, 2'b00, 12'd0, 4'b1111, 2'b00, 7'd80, 1'b0);
  rows[27] = table_row("almful_02", 4'b1111, 2'b00, 12'd0, 4'b1111, 2'b00, 7'd80, 1'b0);
  rows[28] = table_row("almful_03", 4'b1111, 2'b00, 12'd0, 4'b1111, 2'b00, 7'd80, 1'b0);
  rows[29] = table_row("almful_04", 4'b1111, 2'b00, 12'd0, 4'b1111, 2'b00, 7'd80, 1'b0);
  rows[30] = table_row("almful_05", 4'b1111, 2'b00, 12'd0, 4'b1111, 2'b00, 7'd80, 1'b0);
  rows[31] = table_row("almful_06", 4'b1111, 2'b00, 12'd0, 4'b1111, 2'b00, 7'd80, 1'b0);
  rows[32] = table_row("almful_07", 4'b1111, 2'b00, 12'd0, 4'b1111, 2'b00, 7'd80, 1'b0);
  // big drain takes fill from 400 down to 160, then drain keeps pace
  rows[33] = table_row("almful_08", 4'b1111, 2'b00, 12'd320, 4'b1111, 2'b00, 7'd80, 1'b1);
  rows[34] = table_row("almful_09", 4'b1111, 2'b00, 12'd80, 4'b1111, 2'b00, 7'd80, 1'b1);
  rows[35] = table_row("almful_10", 4'b1111, 2'b00, 12'd80, 4'b1111, 2'b00, 7'd80, 1'b0);
  rows[36] = table_row("almful_11", 4'b1111, 2'b00, 12'd80, 4'b1111, 2'b00, 7'd80, 1'b0);
  rows[37] = table_row("almful_12", 4'b1111, 2'b00, 12'd80, 4'b1111, 2'b00, 7'd80, 1'b0);
endtask

// tree leaf order is source channel 2, 0, 3, 1
function automatic int leaf_source(input int leaf);
  case (leaf)
    0: return 2;
    1: return 0;
    2: return 3;
    default: return 1;
  endcase
endfunction

// channels are 8, 16, 24, 32 bits wide, so they start at 0, 8, 24, 48
function automatic int channel_offset(input int ch);
  return 4 * ch * (ch + 1);
endfunction

// valid channels back to back in leaf order, lowest leaf at bit 0
function automatic logb_pkg::logb_data_t pack_reference(
  input logb_pkg::logb_valid_t mask,
  input logb_pkg::logb_data_t  src
);
  logb_pkg::logb_data_t word;
  int pos;
  int ch;
  word = '0;
  pos  = 0;
  for (int leaf = 0; leaf < 4; leaf++) begin
    ch = leaf_source(leaf);
    if (mask[ch]) begin
      for (int b = 0; b < 8 * (ch + 1); b++) begin
        word[pos + b] = src[channel_offset(ch) + b];
      end
      pos = pos + 8 * (ch + 1);
    end
  end
  return word;
endfunction

`endif

//--- verif/trace_logger_tb.sv
`timescale 1ns/100ps

module trace_logger_tb;

  logic                      clk;
  logic                      rstn;
  logb_pkg::logging_in_t     log_in;
  logb_pkg::fill_t           drain_bits;
  logb_pkg::packed_logging_t log_out;
  logic                      logb_almful;

  // random data source and error tallies
  logic [31:0] lfsr_state;
  int          data_errs;
  int          len_errs;
  int          valid_errs;
  int          flag_errs;

  `include "trace_logger_tb_table.svh"

  // data sent with each row, kept for the delayed compare
  logb_pkg::logb_data_t sent_data [ROW_CNT];

  trace_logger_top #(
    .ALMFUL_THRESHOLD (256)
  ) dut (
    .clk         (clk),
    .rstn        (rstn),
    .log_in      (log_in),
    .drain_bits  (drain_bits),
    .log_out     (log_out),
    .logb_almful (logb_almful)
  );

  // 10 ns period
  always #5 clk = ~clk;

  //////////////////////////////////////////////////
  // random data
  //////////////////////////////////////////////////

  // taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    logic feedback;
    feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
    return {state[30:0], feedback};
  endfunction

  // one lfsr step per data bit
  task automatic random_data(output logb_pkg::logb_data_t word);
    for (int i = 0; i < $bits(logb_pkg::logb_data_t); i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      word[i]    = lfsr_state[0];
    end
  endtask

  //////////////////////////////////////////////////
  // compare tasks
  //////////////////////////////////////////////////

  // only the low len bits carry packed data
  task automatic check_data(input name_t name, input logb_pkg::logb_data_t exp_data,
                            input logb_pkg::logb_data_t act_data,
                            input logb_pkg::logb_len_t len);
    logb_pkg::logb_data_t keep;
    keep = ~('1 << len);
    if ((exp_data & keep) !== (act_data & keep)) begin
      data_errs++;
      $display("ERR %0s data expected %h actual %h", name, exp_data & keep, act_data & keep);
    end
  endtask

  task automatic check_len(input name_t name, input logb_pkg::logb_len_t exp_len,
                           input logb_pkg::logb_len_t act_len);
    if (exp_len !== act_len) begin
      len_errs++;
      $display("ERR %0s len expected %0d actual %0d", name, exp_len, act_len);
    end
  endtask

  task automatic check_valids(input name_t name, input logb_pkg::logb_valid_t exp_logb,
                              input logb_pkg::loge_valid_t exp_loge,
                              input logb_pkg::logb_valid_t act_logb,
                              input logb_pkg::loge_valid_t act_loge);
    if (exp_logb !== act_logb || exp_loge !== act_loge) begin
      valid_errs++;
      $display("ERR %0s valids expected %b/%b actual %b/%b", name, exp_logb, exp_loge,
               act_logb, act_loge);
    end
  endtask

  task automatic check_flag(input name_t name, input string label, input logic exp_flag,
                            input logic act_flag);
    if (exp_flag !== act_flag) begin
      flag_errs++;
      $display("ERR %0s %0s expected %b actual %b", name, label, exp_flag, act_flag);
    end
  endtask

  //////////////////////////////////////////////////
  // row handling
  //////////////////////////////////////////////////

  task automatic check_reset_state(input name_t name);
    check_flag(name, "any_valid", 1'b0, log_out.plogb.any_valid);
    check_valids(name, '0, '0, log_out.logb_valid, log_out.loge_valid);
    check_flag(name, "logb_almful", 1'b0, logb_almful);
  endtask

  task automatic apply_row(input int r);
    logb_pkg::logb_data_t word;
    random_data(word);
    sent_data[r]       = word;
    log_in.logb_valid  = rows[r].logb_mask;
    log_in.loge_valid  = rows[r].loge_mask;
    log_in.logb_data   = word;
    drain_bits         = rows[r].drain;
  endtask

  // outputs of row r are stable three cycles after it was driven
  task automatic check_row(input int r);
    row_t                 row;
    logb_pkg::logb_data_t expected;
    row      = rows[r];
    expected = pack_reference(row.logb_mask, sent_data[r]);
    check_flag(row.name, "any_valid", |row.logb_mask, log_out.plogb.any_valid);
    check_valids(row.name, row.exp_logb_valid, row.exp_loge_valid,
                 log_out.logb_valid, log_out.loge_valid);
    check_len(row.name, row.exp_len, log_out.plogb.len);
    check_data(row.name, expected, log_out.plogb.data, row.exp_len);
    check_flag(row.name, "logb_almful", row.exp_almful, logb_almful);
  endtask

  //////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////

  initial begin
    int total_errs;
    clk        = 1'b0;
    rstn       = 1'b0;
    log_in     = '0;
    drain_bits = '0;
    lfsr_state = 32'hd3fcffeb;
    data_errs  = 0;
    len_errs   = 0;
    valid_errs = 0;
    flag_errs  = 0;
    load_table();
    // four reset cycles, outputs must already be clear
    repeat (4) begin
      @(negedge clk);
      check_reset_state("reset");
    end
    rstn = 1'b1;
    @(negedge clk);
    check_reset_state("post_reset");
    // three extra passes flush the last rows through the packer
    for (int k = 0; k < ROW_CNT + 3; k++) begin
      @(negedge clk);
      if (k >= 3) begin
        check_row(k - 3);
      end
      if (k < ROW_CNT) begin
        apply_row(k);
      end else begin
        log_in     = '0;
        drain_bits = '0;
      end
    end
    total_errs = data_errs + len_errs + valid_errs + flag_errs;
    $display("errors: data %0d, len %0d, valids %0d, flags %0d",
             data_errs, len_errs, valid_errs, flag_errs);
    if (total_errs == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  // limit set by the table length plus margin for reset and flush
  initial begin
    #((ROW_CNT + 20) * 10);
    $display("timeout: the run did not finish within %0d ns", (ROW_CNT + 20) * 10);
    $display("Simulation failed");
    $finish;
  end

endmodule

//--- verilog.f
+incdir+verif
source/logb_pkg.sv
source/valid_delay_pipe.sv
source/logb_marshaller2.sv
source/logging_bus_packer.sv
source/trace_fill_monitor.sv
source/trace_logger_top.sv
verif/trace_logger_tb.sv
